// File: sources.f
design/cpu_pkg.sv
design/ex_operand_select.sv
design/ex_compute.sv
design/store_byte_lane.sv
design/exmem_stage.sv
design/execute_stage.sv
test/execute_checker.sv
test/execute_stage_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the execute stage testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f sources.f --top-module execute_stage_tb \
    -Mdir obj_dir -o execute_stage_sim
status=$?
if [ $status -ne 0 ]; then
    echo "Verilator build failed with status $status"
    exit 1
fi

output=$(./obj_dir/execute_stage_sim)
status=$?
printf '%s\n' "$output"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$output" | grep -qx "TEST PASSED"; then
    exit 0
fi
exit 1

// File: test/execute_stage_tb.sv
`timescale 1ns/1ps
`default_nettype none

module execute_stage_tb import cpu_pkg::*; ();

    localparam int       RESET_CYCLES  = 4;
    localparam int       NUM_ROWS      = 42;
    localparam int       CYCLE_LIMIT   = RESET_CYCLES + NUM_ROWS + 20;
    localparam word_t    PC4           = 32'h0000_0100;
    localparam word_t    BRANCH_TARGET = 32'h0000_0140;
    localparam word_t    LOGIC_A       = 32'hf0f0_1234;
    localparam word_t    LOGIC_B       = 32'h0ff0_ff00;
    localparam word_t    SHIFT_DATA    = 32'h8000_00f0;
    localparam word_t    STORE_DATA    = 32'haabb_ccdd;
    localparam fwd_src_t NO_WB         = '0;

    logic          clk;
    logic          reset;
    logic          stall;
    logic          flush;
    idex_bundle_t  idex;
    fwd_src_t      wb;
    exmem_bundle_t exmem;
    logic          check_in;
    int            row_in;
    exmem_bundle_t exp_in;
    int            error_count;
    int            check_count;
    int            cycle_count;
    int            run_errors;
    int            row_fill;

    idex_bundle_t  idex_tab  [NUM_ROWS];
    fwd_src_t      wb_tab    [NUM_ROWS];
    logic          stall_tab [NUM_ROWS];
    logic          flush_tab [NUM_ROWS];
    exmem_bundle_t exp_tab   [NUM_ROWS];

    execute_stage u_dut (
        .clk   (clk),
        .reset (reset),
        .stall (stall),
        .flush (flush),
        .idex  (idex),
        .wb    (wb),
        .exmem (exmem)
    );

    execute_checker u_checker (
        .clk         (clk),
        .exmem       (exmem),
        .check_in    (check_in),
        .row_in      (row_in),
        .exp_in      (exp_in),
        .error_count (error_count),
        .check_count (check_count)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    ////////////////////////////////////////////////////////////
    // Row builders
    ////////////////////////////////////////////////////////////

    // Register ALU op with rs = 1, rt = 2, rd = 3
    function automatic idex_bundle_t alu_instr(input alu_op_e op, input word_t a,
                                               input word_t b);
        idex_bundle_t t;
        t         = '0;
        t.valid   = 1'b1;
        t.pc_4    = PC4;
        t.op_a    = a;
        t.op_b    = b;
        t.rs_addr = 5'd1;
        t.rt_addr = 5'd2;
        t.rd_addr = 5'd3;
        t.alu_op  = op;
        t.reg_w   = 1'b1;
        return t;
    endfunction

    // Store of STORE_DATA to 0x100 plus offset
    function automatic idex_bundle_t store_instr(input store_sel_e sel, input word_t offset);
        idex_bundle_t t;
        t           = alu_instr(ALU_ADD, 32'h0000_0100, STORE_DATA);
        t.reg_w     = 1'b0;
        t.b_sel_imm = 1'b1;
        t.imm_ext   = offset;
        t.mem_w     = 1'b1;
        t.store_sel = sel;
        return t;
    endfunction

    function automatic idex_bundle_t branch_instr(input branch_cond_e cond, input word_t a,
                                                  input word_t b);
        idex_bundle_t t;
        t             = alu_instr(ALU_SUBU, a, b);
        t.reg_w       = 1'b0;
        t.imm_ext     = 32'h0000_0010;
        t.branch_cond = cond;
        return t;
    endfunction

    function automatic fwd_src_t wb_write(input reg_addr_t rd, input word_t data);
        fwd_src_t w;
        w.reg_w   = 1'b1;
        w.rd_addr = rd;
        w.data    = data;
        return w;
    endfunction

    function automatic exmem_bundle_t reg_result(input word_t res, input logic w);
        exmem_bundle_t e;
        e              = '0;
        e.valid        = 1'b1;
        e.reg_w        = w;
        e.rd_addr      = 5'd3;
        e.result       = res;
        e.final_target = PC4;
        return e;
    endfunction

    function automatic exmem_bundle_t store_result(input word_t addr, input byte_en_t en,
                                                   input word_t data);
        exmem_bundle_t e;
        e             = reg_result(addr, 1'b0);
        e.mem_w       = 1'b1;
        e.mem_byte_en = en;
        e.store_data  = data;
        return e;
    endfunction

    function automatic exmem_bundle_t branch_result(input word_t res, input logic taken);
        exmem_bundle_t e;
        e              = reg_result(res, 1'b0);
        e.final_target = taken ? BRANCH_TARGET : PC4;
        return e;
    endfunction

    task automatic insert_row(input idex_bundle_t t, input fwd_src_t w, input logic s,
                              input logic f, input exmem_bundle_t e);
        if (row_fill < NUM_ROWS) begin
            idex_tab[row_fill]  = t;
            wb_tab[row_fill]    = w;
            stall_tab[row_fill] = s;
            flush_tab[row_fill] = f;
            exp_tab[row_fill]   = e;
        end
        row_fill++;
    endtask

    task automatic add_row(input idex_bundle_t t, input exmem_bundle_t e);
        insert_row(t, NO_WB, 1'b0, 1'b0, e);
    endtask

    ////////////////////////////////////////////////////////////
    // Stimulus table
    ////////////////////////////////////////////////////////////

    task automatic build_table();
        idex_bundle_t  t;
        exmem_bundle_t e;
        add_row(alu_instr(ALU_ADD, 32'd5, 32'd7), reg_result(32'h0000_000c, 1'b1));
        add_row(alu_instr(ALU_SUB, 32'd5, 32'd7), reg_result(32'hffff_fffe, 1'b1));
        add_row(alu_instr(ALU_AND, LOGIC_A, LOGIC_B), reg_result(32'h00f0_1200, 1'b1));
        add_row(alu_instr(ALU_OR, LOGIC_A, LOGIC_B), reg_result(32'hfff0_ff34, 1'b1));
        add_row(alu_instr(ALU_XOR, LOGIC_A, LOGIC_B), reg_result(32'hff00_ed34, 1'b1));
        add_row(alu_instr(ALU_NOR, LOGIC_A, LOGIC_B), reg_result(32'h000f_00cb, 1'b1));
        add_row(alu_instr(ALU_SLT, 32'hffff_ffff, 32'd1), reg_result(32'd1, 1'b1));
        add_row(alu_instr(ALU_SLTU, 32'hffff_ffff, 32'd1), reg_result(32'd0, 1'b1));
        t = alu_instr(ALU_LUI, 32'd0, 32'd0);
        t.b_sel_imm = 1'b1;
        t.imm_ext   = 32'h0000_abcd;
        add_row(t, reg_result(32'habcd_0000, 1'b1));
        // Signed overflow blocks the write only for add
        t = alu_instr(ALU_ADD, 32'h7fff_ffff, 32'd1);
        t.of_w_disable = 1'b1;
        add_row(t, reg_result(32'h8000_0000, 1'b0));
        t.alu_op = ALU_ADDU;
        add_row(t, reg_result(32'h8000_0000, 1'b1));

        // Shifts act on rt
        t = alu_instr(ALU_ADDU, 32'd0, SHIFT_DATA);
        t.exres_sel = EXRES_SHIFT;
        t.shamt     = 5'd4;
        add_row(t, reg_result(32'h0000_0f00, 1'b1));
        t.shift_op = SHIFT_SRL;
        add_row(t, reg_result(32'h0800_000f, 1'b1));
        t.shift_op = SHIFT_SRA;
        add_row(t, reg_result(32'hf800_000f, 1'b1));
        t.shamt_from_reg = 1'b1;
        t.op_a           = 32'h0000_0028;
        add_row(t, reg_result(32'hff80_0000, 1'b1));
        t.shift_op = SHIFT_SLL;
        t.op_a     = 32'hffff_ffe3;
        add_row(t, reg_result(32'h0000_0780, 1'b1));

        // Forwarding
        t = alu_instr(ALU_ADD, 32'h10, 32'h20);
        t.rd_addr = 5'd5;
        e = reg_result(32'h30, 1'b1);
        e.rd_addr = 5'd5;
        add_row(t, e);
        t = alu_instr(ALU_ADD, 32'hdead, 32'd1);
        t.rs_addr = 5'd5;
        insert_row(t, wb_write(5'd5, 32'h999), 1'b0, 1'b0, reg_result(32'h31, 1'b1));
        // rt picks up the MEM result too
        t = alu_instr(ALU_ADD, 32'h40, 32'hbad);
        t.rt_addr = 5'd3;
        add_row(t, reg_result(32'h71, 1'b1));
        t = alu_instr(ALU_ADD, 32'hbad, 32'd2);
        t.rs_addr = 5'd7;
        t.rd_addr = 5'd0;
        e = reg_result(32'h102, 1'b1);
        e.rd_addr = 5'd0;
        insert_row(t, wb_write(5'd7, 32'h100), 1'b0, 1'b0, e);
        // $0 sits in both MEM and WB here
        t = alu_instr(ALU_ADD, 32'd4, 32'd3);
        t.rs_addr = 5'd0;
        insert_row(t, wb_write(5'd0, 32'h500), 1'b0, 1'b0, reg_result(32'd7, 1'b1));

        // Conditional moves
        t = alu_instr(ALU_ADDU, 32'h1234_5678, 32'd0);
        t.movz = 1'b1;
        add_row(t, reg_result(32'h1234_5678, 1'b1));
        t.op_b = 32'd5;
        add_row(t, reg_result(32'h1234_5678, 1'b0));
        t.movz = 1'b0;
        t.movn = 1'b1;
        add_row(t, reg_result(32'h1234_5678, 1'b1));
        t.op_b = 32'd0;
        add_row(t, reg_result(32'h1234_5678, 1'b0));

        // Stores at every legal offset
        add_row(store_instr(STORE_WORD, 32'd0), store_result(32'h100, 4'b1111, STORE_DATA));
        for (int h = 0; h < 2; h++) begin
            add_row(store_instr(STORE_HALF, word_t'(2 * h)),
                    store_result(32'h100 + word_t'(2 * h), byte_en_t'(4'b0011 << (2 * h)),
                                 32'hccdd_ccdd));
        end
        for (int b = 0; b < 4; b++) begin
            add_row(store_instr(STORE_BYTE, word_t'(b)),
                    store_result(32'h100 + word_t'(b), byte_en_t'(4'b0001 << b),
                                 32'hdddd_dddd));
        end

        // Load address with mem_r carried through
        t = alu_instr(ALU_ADD, 32'h0000_0100, 32'd0);
        t.b_sel_imm = 1'b1;
        t.imm_ext   = 32'h0000_0008;
        t.mem_r     = 1'b1;
        e = reg_result(32'h0000_0108, 1'b1);
        e.mem_r = 1'b1;
        add_row(t, e);

        // Branches on A minus B
        add_row(branch_instr(BR_EQ, 32'd5, 32'd5), branch_result(32'd0, 1'b1));
        add_row(branch_instr(BR_NE, 32'd5, 32'd5), branch_result(32'd0, 1'b0));
        add_row(branch_instr(BR_LT, 32'hffff_ffff, 32'd1), branch_result(32'hffff_fffe, 1'b1));
        add_row(branch_instr(BR_GE, 32'hffff_ffff, 32'd1), branch_result(32'hffff_fffe, 1'b0));
        add_row(branch_instr(BR_LE, 32'd5, 32'd5), branch_result(32'd0, 1'b1));
        add_row(branch_instr(BR_GT, 32'd7, 32'd3), branch_result(32'd4, 1'b1));
        // jr target is rs plus zero through a taken ge
        t = branch_instr(BR_GE, 32'h0000_2000, 32'd0);
        t.jr     = 1'b1;
        t.alu_op = ALU_ADDU;
        e = reg_result(32'h0000_2000, 1'b0);
        e.final_target = 32'h0000_2000;
        add_row(t, e);
        insert_row(alu_instr(ALU_ADD, 32'd1, 32'd1), NO_WB, 1'b1, 1'b0, e);
        insert_row(alu_instr(ALU_ADD, 32'd1, 32'd1), NO_WB, 1'b0, 1'b1, '0);
    endtask

    task automatic apply_row(input int k);
        idex   = idex_tab[k];
        wb     = wb_tab[k];
        stall  = stall_tab[k];
        flush  = flush_tab[k];
        exp_in = exp_tab[k];
        row_in = k;
    endtask

    ////////////////////////////////////////////////////////////
    // Run control
    ////////////////////////////////////////////////////////////

    initial begin
        reset      = 1'b1;
        stall      = 1'b0;
        flush      = 1'b0;
        idex       = '0;
        wb         = '0;
        check_in   = 1'b1;
        row_in     = -1;
        exp_in     = '0;
        run_errors = 0;
        row_fill   = 0;
        build_table();
        if (row_fill != NUM_ROWS) begin
            $display("stimulus table holds %0d rows instead of %0d", row_fill, NUM_ROWS);
            run_errors++;
        end
        repeat (RESET_CYCLES) @(posedge clk);
        #2;
        reset = 1'b0;
        for (int k = 0; k < NUM_ROWS; k++) begin
            apply_row(k);
            @(posedge clk);
            #2;
        end
        check_in = 1'b0;
        idex     = '0;
        repeat (2) @(posedge clk);
        if (check_count != RESET_CYCLES + NUM_ROWS) begin
            $display("checker ran %0d checks instead of %0d", check_count,
                     RESET_CYCLES + NUM_ROWS);
            run_errors++;
        end
        $display("checks %0d, errors %0d", check_count, error_count + run_errors);
        if (error_count + run_errors == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

    initial begin
        cycle_count = 0;
        while (cycle_count < CYCLE_LIMIT) begin
            @(posedge clk);
            cycle_count++;
        end
        $display("timeout: run still going after %0d clock cycles", CYCLE_LIMIT);
        $display("TEST FAILED");
        $finish;
    end

endmodule

`default_nettype wire

// File: test/execute_checker.sv
`timescale 1ns/1ps
`default_nettype none

module execute_checker import cpu_pkg::*; (
    input  logic          clk,
    input  exmem_bundle_t exmem,
    input  logic          check_in,
    input  int            row_in,
    input  exmem_bundle_t exp_in,
    output int            error_count,
    output int            check_count
);

    logic          check_q;
    int            row_q;
    exmem_bundle_t want_q;
    int            err_cnt = 0;
    int            chk_cnt = 0;

    assign error_count = err_cnt;
    assign check_count = chk_cnt;

    task automatic compare_field(input int row, input string name, input word_t got,
                                 input word_t want);
        if (got !== want) begin
            err_cnt++;
            $display("mismatch row %0d %s: got %h expected %h", row, name, got, want);
        end
    endtask

    // Expectation for the instruction captured at this edge
    always @(posedge clk) begin
        check_q <= check_in;
        row_q   <= row_in;
        want_q  <= exp_in;
    end

    // EX/MEM output is settled by the falling edge
    always @(negedge clk) begin
        if (check_q) begin
            chk_cnt++;
            compare_field(row_q, "valid", word_t'(exmem.valid), word_t'(want_q.valid));
            compare_field(row_q, "reg_w", word_t'(exmem.reg_w), word_t'(want_q.reg_w));
            compare_field(row_q, "rd_addr", word_t'(exmem.rd_addr), word_t'(want_q.rd_addr));
            compare_field(row_q, "result", exmem.result, want_q.result);
            compare_field(row_q, "mem_r", word_t'(exmem.mem_r), word_t'(want_q.mem_r));
            compare_field(row_q, "mem_w", word_t'(exmem.mem_w), word_t'(want_q.mem_w));
            compare_field(row_q, "mem_byte_en", word_t'(exmem.mem_byte_en),
                          word_t'(want_q.mem_byte_en));
            compare_field(row_q, "store_data", exmem.store_data, want_q.store_data);
            compare_field(row_q, "final_target", exmem.final_target, want_q.final_target);
        end
    end

endmodule

`default_nettype wire

// File: design/execute_stage.sv
`timescale 1ns/1ps
`default_nettype none

module execute_stage import cpu_pkg::*; (
    input  logic          clk,
    input  logic          reset,
    input  logic          stall,
    input  logic          flush,
    input  idex_bundle_t  idex,
    input  fwd_src_t      wb,
    output exmem_bundle_t exmem
);

    word_t    fwd_a;
    word_t    fwd_b;
    word_t    alu_a;
    word_t    alu_b;
    shamt_t   shamt;
    word_t    result;
    word_t    branch_addr;
    logic     less;
    logic     zero;
    logic     overflow;
    word_t    store_data;
    byte_en_t mem_byte_en;

    // MEM forwarding comes straight from the registered stage output
    ex_operand_select u_operand_select (
        .idex    (idex),
        .mem_fwd (exmem),
        .wb      (wb),
        .fwd_a   (fwd_a),
        .fwd_b   (fwd_b),
        .alu_a   (alu_a),
        .alu_b   (alu_b),
        .shamt   (shamt)
    );

    ex_compute u_compute (
        .idex        (idex),
        .fwd_a       (fwd_a),
        .fwd_b       (fwd_b),
        .alu_a       (alu_a),
        .alu_b       (alu_b),
        .shamt       (shamt),
        .result      (result),
        .branch_addr (branch_addr),
        .less        (less),
        .zero        (zero),
        .overflow    (overflow)
    );

    // Store address is the ALU result
    for (genvar i = 0; i < BYTES_PER_WORD; i++) begin : g_lane
        store_byte_lane #(.LANE(i)) u_lane (
            .addr_low  (result[1:0]),
            .store_sel (idex.store_sel),
            .rt_data   (fwd_b),
            .lane_data (store_data[8*i +: 8]),
            .lane_en   (mem_byte_en[i])
        );
    end

    exmem_stage u_exmem (
        .clk         (clk),
        .reset       (reset),
        .stall       (stall),
        .flush       (flush),
        .idex        (idex),
        .result      (result),
        .branch_addr (branch_addr),
        .less        (less),
        .zero        (zero),
        .overflow    (overflow),
        .fwd_b       (fwd_b),
        .store_data  (store_data),
        .mem_byte_en (mem_byte_en),
        .exmem       (exmem)
    );

endmodule

`default_nettype wire

// File: design/exmem_stage.sv
`timescale 1ns/1ps
`default_nettype none

module exmem_stage import cpu_pkg::*; (
    input  logic          clk,
    input  logic          reset,
    input  logic          stall,
    input  logic          flush,
    input  idex_bundle_t  idex,
    input  word_t         result,
    input  word_t         branch_addr,
    input  logic          less,
    input  logic          zero,
    input  logic          overflow,
    input  word_t         fwd_b,
    input  word_t         store_data,
    input  byte_en_t      mem_byte_en,
    output exmem_bundle_t exmem
);

    logic          reg_w_gated;
    logic          taken;
    exmem_bundle_t next_exmem;

    ////////////////////////////////////////////////////////////
    // Register write and branch resolution
    ////////////////////////////////////////////////////////////

    always_comb begin
        reg_w_gated = idex.reg_w;
        if (overflow && idex.of_w_disable) begin
            reg_w_gated = 1'b0;
        end
        // Conditional moves look at rt itself
        if (idex.movz) begin
            reg_w_gated = idex.reg_w && (fwd_b == '0);
        end else if (idex.movn) begin
            reg_w_gated = idex.reg_w && (fwd_b != '0);
        end
    end

    always_comb begin
        case (idex.branch_cond)
            BR_EQ:   taken = zero;
            BR_NE:   taken = !zero;
            BR_LT:   taken = less;
            BR_GE:   taken = !less;
            BR_LE:   taken = less || zero;
            BR_GT:   taken = !less && !zero;
            default: taken = 1'b0;
        endcase
    end

    always_comb begin
        next_exmem.valid        = idex.valid;
        next_exmem.reg_w        = reg_w_gated;
        next_exmem.rd_addr      = idex.rd_addr;
        next_exmem.result       = result;
        next_exmem.mem_r        = idex.mem_r;
        next_exmem.mem_w        = idex.mem_w;
        next_exmem.mem_byte_en  = mem_byte_en;
        next_exmem.store_data   = store_data;
        next_exmem.final_target = taken ? branch_addr : idex.pc_4;
    end

    // Bubble is the all zero bundle
    always_ff @(posedge clk) begin
        if (reset || (flush && !stall)) begin
            exmem <= '0;
        end else if (!stall) begin
            exmem <= next_exmem;
        end
    end

    a_no_stall_flush: assert property (@(posedge clk) disable iff (reset) !(stall && flush));

    a_store_has_lanes: assert property (@(posedge clk) disable iff (reset)
        exmem.mem_w |-> exmem.mem_byte_en != '0);

endmodule

`default_nettype wire

// File: design/store_byte_lane.sv
`timescale 1ns/1ps
`default_nettype none

module store_byte_lane import cpu_pkg::*; #(
    parameter int unsigned LANE = 0
) (
    input  logic [1:0] addr_low,
    input  store_sel_e store_sel,
    input  word_t      rt_data,
    output logic [7:0] lane_data,
    output logic       lane_en
);

    localparam logic [1:0] LANE_IDX = LANE[1:0];

    always_comb begin
        case (store_sel)
            STORE_WORD: begin
                lane_data = rt_data[8*LANE +: 8];
                lane_en   = 1'b1;
            end
            // Halfword repeats on both halves and bit 1 picks the written half
            STORE_HALF: begin
                lane_data = rt_data[8*(LANE%2) +: 8];
                lane_en   = (addr_low[1] == LANE_IDX[1]);
            end
            STORE_BYTE: begin
                lane_data = rt_data[7:0];
                lane_en   = (addr_low == LANE_IDX);
            end
            default: begin
                lane_data = '0;
                lane_en   = 1'b0;
            end
        endcase
    end

endmodule

`default_nettype wire

// File: design/ex_compute.sv
`timescale 1ns/1ps
`default_nettype none

module ex_compute import cpu_pkg::*; (
    input  idex_bundle_t idex,
    input  word_t        fwd_a,
    input  word_t        fwd_b,
    input  word_t        alu_a,
    input  word_t        alu_b,
    input  shamt_t       shamt,
    output word_t        result,
    output word_t        branch_addr,
    output logic         less,
    output logic         zero,
    output logic         overflow
);

    word_t sum;
    word_t diff;
    word_t alu_out;
    word_t shift_out;
    logic  add_ovf;
    logic  sub_ovf;

    ////////////////////////////////////////////////////////////
    // ALU
    ////////////////////////////////////////////////////////////

    assign sum  = alu_a + alu_b;
    assign diff = alu_a - alu_b;

    // Signed overflow on the two adders
    assign add_ovf = (alu_a[DATA_WIDTH-1] == alu_b[DATA_WIDTH-1]) &&
                     (sum[DATA_WIDTH-1] != alu_a[DATA_WIDTH-1]);
    assign sub_ovf = (alu_a[DATA_WIDTH-1] != alu_b[DATA_WIDTH-1]) &&
                     (diff[DATA_WIDTH-1] != alu_a[DATA_WIDTH-1]);

    // Flags of A minus B, used by slt and the branch unit
    assign less = diff[DATA_WIDTH-1] ^ sub_ovf;
    assign zero = (diff == '0);

    always_comb begin
        overflow = 1'b0;
        case (idex.alu_op)
            ALU_ADD: begin
                alu_out  = sum;
                overflow = add_ovf;
            end
            ALU_ADDU: alu_out = sum;
            ALU_SUB: begin
                alu_out  = diff;
                overflow = sub_ovf;
            end
            ALU_SUBU: alu_out = diff;
            ALU_AND:  alu_out = alu_a & alu_b;
            ALU_OR:   alu_out = alu_a | alu_b;
            ALU_XOR:  alu_out = alu_a ^ alu_b;
            ALU_NOR:  alu_out = ~(alu_a | alu_b);
            ALU_SLT:  alu_out = word_t'(less);
            ALU_SLTU: alu_out = word_t'(alu_a < alu_b);
            ALU_LUI:  alu_out = {alu_b[15:0], 16'h0000};
            default:  alu_out = '0;
        endcase
    end

    ////////////////////////////////////////////////////////////
    // Shifter and result select
    ////////////////////////////////////////////////////////////

    always_comb begin
        case (idex.shift_op)
            SHIFT_SRL: shift_out = fwd_b >> shamt;
            SHIFT_SRA: shift_out = word_t'($signed(fwd_b) >>> shamt);
            default:   shift_out = fwd_b << shamt;
        endcase
    end

    // jr takes rs through the ALU
    assign branch_addr = idex.jr ? alu_out : idex.pc_4 + (idex.imm_ext << 2);

    always_comb begin
        case (idex.exres_sel)
            EXRES_SHIFT:  result = shift_out;
            EXRES_LINK:   result = branch_addr;
            EXRES_PASS_A: result = fwd_a;
            default:      result = alu_out;
        endcase
    end

endmodule

`default_nettype wire

// File: design/ex_operand_select.sv
`timescale 1ns/1ps
`default_nettype none

module ex_operand_select import cpu_pkg::*; (
    input  idex_bundle_t  idex,
    input  exmem_bundle_t mem_fwd,
    input  fwd_src_t      wb,
    output word_t         fwd_a,
    output word_t         fwd_b,
    output word_t         alu_a,
    output word_t         alu_b,
    output shamt_t        shamt
);

    fwd_sel_e sel_a;
    fwd_sel_e sel_b;

    // MEM wins over WB, and $0 is never forwarded
    function automatic fwd_sel_e pick_src(input reg_addr_t src);
        fwd_sel_e sel;
        sel = FWD_IDEX;
        if (src != '0) begin
            if (mem_fwd.reg_w && mem_fwd.rd_addr == src) begin
                sel = FWD_MEM;
            end else if (wb.reg_w && wb.rd_addr == src) begin
                sel = FWD_WB;
            end
        end
        return sel;
    endfunction

    function automatic word_t fwd_data(input fwd_sel_e sel, input word_t own);
        word_t data;
        case (sel)
            FWD_MEM: data = mem_fwd.result;
            FWD_WB:  data = wb.data;
            default: data = own;
        endcase
        return data;
    endfunction

    always_comb begin
        sel_a = pick_src(idex.rs_addr);
        sel_b = pick_src(idex.rt_addr);
        fwd_a = fwd_data(sel_a, idex.op_a);
        fwd_b = fwd_data(sel_b, idex.op_b);
    end

    // Moves run as 0 + rs while rt only decides the write
    assign alu_a = (idex.movz || idex.movn) ? '0 : fwd_a;
    assign alu_b = (idex.movz || idex.movn) ? fwd_a :
                   (idex.b_sel_imm ? idex.imm_ext : fwd_b);
    assign shamt = idex.shamt_from_reg ? fwd_a[4:0] : idex.shamt;

    // Relies on the EX/MEM bubble clearing reg_w
    always_comb begin
        if (sel_a == FWD_MEM || sel_b == FWD_MEM) begin
            a_mem_fwd_valid: assert (mem_fwd.valid)
                else $error("forwarding from a bubble in MEM");
        end
    end

endmodule

`default_nettype wire

// File: design/cpu_pkg.sv
`default_nettype none

package cpu_pkg;

    localparam int DATA_WIDTH     = 32;
    localparam int REG_ADDR_WIDTH = 5;
    localparam int BYTES_PER_WORD = 4;

    typedef logic [DATA_WIDTH-1:0]     word_t;
    typedef logic [REG_ADDR_WIDTH-1:0] reg_addr_t;
    typedef logic [4:0]                shamt_t;
    typedef logic [BYTES_PER_WORD-1:0] byte_en_t;

    ////////////////////////////////////////////////////////////
    // Selector codes
    ////////////////////////////////////////////////////////////

    typedef enum logic [3:0] {
        ALU_ADD, ALU_ADDU, ALU_SUB, ALU_SUBU, ALU_AND, ALU_OR,
        ALU_XOR, ALU_NOR, ALU_SLT, ALU_SLTU, ALU_LUI
    } alu_op_e;

    typedef enum logic [1:0] {SHIFT_SLL, SHIFT_SRL, SHIFT_SRA} shift_op_e;

    typedef enum logic [1:0] {EXRES_ALU, EXRES_SHIFT, EXRES_LINK, EXRES_PASS_A} exres_sel_e;

    typedef enum logic [2:0] {BR_NONE, BR_EQ, BR_NE, BR_LT, BR_GE, BR_LE, BR_GT} branch_cond_e;

    typedef enum logic [1:0] {STORE_NONE, STORE_WORD, STORE_HALF, STORE_BYTE} store_sel_e;

    typedef enum logic [1:0] {FWD_IDEX, FWD_MEM, FWD_WB} fwd_sel_e;

    ////////////////////////////////////////////////////////////
    // Pipeline bundles
    ////////////////////////////////////////////////////////////

    // Write-back source as seen by the forwarding logic
    typedef struct packed {
        logic      reg_w;
        reg_addr_t rd_addr;
        word_t     data;
    } fwd_src_t;

    typedef struct packed {
        logic         valid;
        word_t        pc_4;
        word_t        op_a;
        word_t        op_b;
        reg_addr_t    rs_addr;
        reg_addr_t    rt_addr;
        reg_addr_t    rd_addr;
        word_t        imm_ext;
        alu_op_e      alu_op;
        logic         b_sel_imm;
        shift_op_e    shift_op;
        shamt_t       shamt;
        logic         shamt_from_reg;
        exres_sel_e   exres_sel;
        logic         reg_w;
        logic         of_w_disable;
        logic         movz;
        logic         movn;
        logic         jr;
        logic         mem_r;
        logic         mem_w;
        store_sel_e   store_sel;
        branch_cond_e branch_cond;
    } idex_bundle_t;

    typedef struct packed {
        logic      valid;
        logic      reg_w;
        reg_addr_t rd_addr;
        word_t     result;
        logic      mem_r;
        logic      mem_w;
        byte_en_t  mem_byte_en;
        word_t     store_data;
        word_t     final_target;
    } exmem_bundle_t;

endpackage

`default_nettype wire
